/* rtl/st7789_pkg.sv */
//######################################
// ST7789 panel definitions
// command codes, command item layout, table sizes and delay
// types shared by the sequencer, command table and serializer
//######################################
package st7789_pkg;

    typedef logic [7:0]  byte_t;      // one byte on the SPI wire
    typedef logic [19:0] cycles_t;    // delay length in clock cycles
    typedef logic [3:0]  item_idx_t;  // command table index

    // one SPI transfer with its DC level
    typedef struct packed {
        logic  dc;    // 0 = command, 1 = parameter or pixel
        byte_t data;
    } lcd_item_t;

    // table lengths
    localparam int INIT_ITEMS   = 9;
    localparam int WINDOW_ITEMS = 11;

    // ST7789 command codes
    localparam byte_t CMD_SWRESET = 8'h01;
    localparam byte_t CMD_SLPOUT  = 8'h11;
    localparam byte_t CMD_COLMOD  = 8'h3A;
    localparam byte_t CMD_MADCTL  = 8'h36;
    localparam byte_t CMD_INVON   = 8'h21;
    localparam byte_t CMD_NORON   = 8'h13;
    localparam byte_t CMD_DISPON  = 8'h29;
    localparam byte_t CMD_CASET   = 8'h2A;
    localparam byte_t CMD_RASET   = 8'h2B;
    localparam byte_t CMD_RAMWR   = 8'h2C;

    // init parameters
    localparam byte_t PAR_COLMOD_565 = 8'h55;  // 16 bit per pixel
    localparam byte_t PAR_MADCTL_RGB = 8'h00;  // no mirror, RGB order

endpackage

/* rtl/pixel_pkg.sv */
//######################################
// upstream pixel stream types
// pixel format and the counter type used for
// credits and buffer fill
//######################################
package pixel_pkg;

    // RGB565, red in the top bits
    typedef logic [15:0] pixel_t;

    // credit and fill counter, enough for depths up to 8
    typedef logic [3:0] credit_cnt_t;

endpackage

/* rtl/lcd_delay_timer.sv */
//######################################
// loadable delay timer
// load with start and a cycle count; done stays high
// from expiry until the next start
//######################################
`timescale 1ns/1ns

module lcd_delay_timer (
    input  logic                w_clk,
    input  logic                reset,
    input  logic                start,
    input  st7789_pkg::cycles_t cycles,
    output logic                done
);
    import st7789_pkg::*;

    cycles_t cnt;

    always_ff @(posedge w_clk) begin
        if (reset) begin
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            cnt  <= cycles;
            done <= (cycles == '0);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
            if (cnt == cycles_t'(1)) done <= 1'b1;   // reaching zero
        end
    end

endmodule

/* rtl/lcd_command_rom.sv */
//######################################
// ST7789 command tables
// init list and per-frame window list, read combinationally;
// window ends follow the panel size
//######################################
`timescale 1ns/1ns

module lcd_command_rom #(
    parameter int PANEL_W = 240,
    parameter int PANEL_H = 240
) (
    input  st7789_pkg::item_idx_t idx,
    input  logic                  window,
    output st7789_pkg::lcd_item_t item
);
    import st7789_pkg::*;

    localparam logic [15:0] COL_END = 16'(PANEL_W - 1);
    localparam logic [15:0] ROW_END = 16'(PANEL_H - 1);

    function automatic lcd_item_t cmd(input byte_t code);
        return '{dc: 1'b0, data: code};
    endfunction

    function automatic lcd_item_t par(input byte_t value);
        return '{dc: 1'b1, data: value};
    endfunction

    always_comb begin
        item = cmd(8'h00);   // nop outside the tables
        if (!window) begin
            case (idx)
                4'd0: item = cmd(CMD_SWRESET);
                4'd1: item = cmd(CMD_SLPOUT);
                4'd2: item = cmd(CMD_COLMOD);
                4'd3: item = par(PAR_COLMOD_565);
                4'd4: item = cmd(CMD_MADCTL);
                4'd5: item = par(PAR_MADCTL_RGB);
                4'd6: item = cmd(CMD_INVON);
                4'd7: item = cmd(CMD_NORON);
                4'd8: item = cmd(CMD_DISPON);
                default: ;
            endcase
        end else begin
            case (idx)
                4'd0:  item = cmd(CMD_CASET);
                4'd1:  item = par(8'h00);          // column start
                4'd2:  item = par(8'h00);
                4'd3:  item = par(COL_END[15:8]);  // column end
                4'd4:  item = par(COL_END[7:0]);
                4'd5:  item = cmd(CMD_RASET);
                4'd6:  item = par(8'h00);          // row start
                4'd7:  item = par(8'h00);
                4'd8:  item = par(ROW_END[15:8]);  // row end
                4'd9:  item = par(ROW_END[7:0]);
                4'd10: item = cmd(CMD_RAMWR);
                default: ;
            endcase
        end
    end

endmodule

/* rtl/pixel_credit_fifo.sv */
//######################################
// credit based pixel buffer
// circular buffer of FIFO_DEPTH pixels; grants FIFO_DEPTH
// credits after reset and one more per popped pixel
//######################################
`timescale 1ns/1ns

module pixel_credit_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              w_clk,
    input  logic              reset,
    input  logic              push,
    input  pixel_pkg::pixel_t push_pix,
    output logic              credit,
    input  logic              pop,
    output logic              buf_valid,
    output pixel_pkg::pixel_t buf_pix
);
    import pixel_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST = PTR_W'(FIFO_DEPTH - 1);

    pixel_t           mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    credit_cnt_t      fill;
    credit_cnt_t      owed;     // initial credits not yet granted

    assign buf_valid = (fill != '0);
    assign buf_pix   = mem[rd_ptr];

    always_ff @(posedge w_clk) begin
        if (push) mem[wr_ptr] <= push_pix;
    end

    always_ff @(posedge w_clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == LAST) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == LAST) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: ;
            endcase
        end
    end

    // a pop takes the slot this cycle, owed credits wait one
    always_ff @(posedge w_clk) begin
        if (reset) begin
            credit <= 1'b0;
            owed   <= credit_cnt_t'(FIFO_DEPTH);
        end else if (pop) begin
            credit <= 1'b1;
        end else if (owed != '0) begin
            credit <= 1'b1;
            owed   <= owed - 1'b1;
        end else begin
            credit <= 1'b0;
        end
    end

endmodule

/* rtl/spi_byte_tx.sv */
//######################################
// 3-wire SPI byte serializer
// takes one command item, sends it MSB first with SCL idle
// high; busy for 18 cycles from acceptance
//######################################
`timescale 1ns/1ns

module spi_byte_tx (
    input  logic                  w_clk,
    input  logic                  reset,
    input  st7789_pkg::lcd_item_t item,
    input  logic                  item_valid,
    output logic                  ready,
    output logic                  sda,
    output logic                  scl,
    output logic                  dc
);
    import st7789_pkg::*;

    logic       busy;
    logic [4:0] cnt;     // cycle within the byte, 1 to 18
    byte_t      shreg;

    assign ready = !busy;
    assign sda   = shreg[7];

    // cycle 1 setup with SCL high, then 8 bits of low/high pairs,
    // cycle 18 idle high before ready returns
    always_ff @(posedge w_clk) begin
        if (reset) begin
            busy  <= 1'b0;
            cnt   <= '0;
            scl   <= 1'b1;
            dc    <= 1'b0;
            shreg <= '0;
        end else if (item_valid && !busy) begin
            busy  <= 1'b1;
            cnt   <= 5'd1;
            shreg <= item.data;   // MSB shows at once
            dc    <= item.dc;
        end else if (busy) begin
            cnt <= cnt + 1'b1;
            if (cnt >= 5'd1 && cnt <= 5'd16) scl <= ~scl;
            // next bit as SCL falls
            if (cnt[0] && cnt >= 5'd3 && cnt <= 5'd15) shreg <= {shreg[6:0], 1'b0};
            if (cnt == 5'd18) busy <= 1'b0;
        end
    end

endmodule

/* rtl/lcd_sequencer.sv */
//######################################
// panel bring-up and frame sequencer
// pulses the panel reset, sends the spaced init list, then loops
// over window commands and pixel bytes, high byte first
//######################################
`timescale 1ns/1ns

module lcd_sequencer #(
    parameter int PANEL_W      = 240,
    parameter int PANEL_H      = 240,
    parameter int RESET_CYCLES = 10000,
    parameter int WAKE_CYCLES  = 10000,
    parameter int INIT_GAP     = 2048
) (
    input  logic                  w_clk,
    input  logic                  reset,
    output logic                  lcd_res,
    output logic                  tmr_start,
    output st7789_pkg::cycles_t   tmr_cycles,
    input  logic                  tmr_done,
    output st7789_pkg::item_idx_t tbl_idx,
    output logic                  tbl_window,
    input  st7789_pkg::lcd_item_t tbl_item,
    input  logic                  buf_valid,
    input  pixel_pkg::pixel_t     buf_pix,
    output logic                  pop,
    output st7789_pkg::lcd_item_t item,
    output logic                  item_valid,
    input  logic                  tx_ready
);
    import st7789_pkg::*;

    localparam int FRAME_PIX = PANEL_W * PANEL_H;
    localparam int PIX_CNT_W = $clog2(FRAME_PIX + 1);

    // timer loads, shortened by the start and state pipeline cycles
    localparam cycles_t RESET_LOAD = cycles_t'(RESET_CYCLES - 1);
    localparam cycles_t WAKE_LOAD  = cycles_t'(WAKE_CYCLES - 2);
    localparam cycles_t GAP_LOAD   = cycles_t'(INIT_GAP - 3);

    typedef enum logic [2:0] {
        RESET_LOW,
        WAKE,
        INIT_SEND,
        INIT_WAIT,
        WINDOW,
        PIX_HI,
        PIX_LO
    } seq_state_t;

    seq_state_t           state;
    logic [PIX_CNT_W-1:0] pix_cnt;   // pixels sent in this frame
    byte_t                pix_lo;    // low byte of the popped pixel
    logic                 accept;
    logic                 tmr_over;

    assign accept     = item_valid && tx_ready;
    assign tmr_over   = tmr_done && !tmr_start;  // done is stale in the start cycle
    assign tbl_window = (state == WINDOW);

    always_comb begin
        item_valid = 1'b0;
        item       = tbl_item;
        pop        = 1'b0;
        case (state)
            INIT_SEND, WINDOW: item_valid = 1'b1;
            PIX_HI: begin
                item_valid = buf_valid;   // stall with SCL idle when empty
                item       = '{dc: 1'b1, data: buf_pix[15:8]};
                pop        = buf_valid && tx_ready;
            end
            PIX_LO: begin
                item_valid = 1'b1;
                item       = '{dc: 1'b1, data: pix_lo};
            end
            default: ;
        endcase
    end

    always_ff @(posedge w_clk) begin
        if (reset) begin
            state      <= RESET_LOW;
            lcd_res    <= 1'b0;
            tmr_start  <= 1'b1;        // time the reset pulse right away
            tmr_cycles <= RESET_LOAD;
            tbl_idx    <= '0;
            pix_cnt    <= '0;
        end else begin
            tmr_start <= 1'b0;
            case (state)
                RESET_LOW: if (tmr_over) begin
                    lcd_res    <= 1'b1;
                    tmr_start  <= 1'b1;
                    tmr_cycles <= WAKE_LOAD;
                    state      <= WAKE;
                end
                WAKE: if (tmr_over) state <= INIT_SEND;
                INIT_SEND: if (accept) begin
                    tmr_start  <= 1'b1;
                    tmr_cycles <= GAP_LOAD;
                    state      <= INIT_WAIT;
                    if (tbl_idx == item_idx_t'(INIT_ITEMS - 1)) tbl_idx <= '0;
                    else tbl_idx <= tbl_idx + 1'b1;
                end
                INIT_WAIT: if (tmr_over) begin
                    // index wrapped, so the list is done
                    state <= (tbl_idx == '0) ? WINDOW : INIT_SEND;
                end
                WINDOW: if (accept) begin
                    if (tbl_idx == item_idx_t'(WINDOW_ITEMS - 1)) begin
                        tbl_idx <= '0;
                        state   <= PIX_HI;
                    end else begin
                        tbl_idx <= tbl_idx + 1'b1;
                    end
                end
                PIX_HI: if (accept) state <= PIX_LO;
                PIX_LO: if (accept) begin
                    if (pix_cnt == PIX_CNT_W'(FRAME_PIX - 1)) begin
                        pix_cnt <= '0;
                        state   <= WINDOW;   // next frame
                    end else begin
                        pix_cnt <= pix_cnt + 1'b1;
                        state   <= PIX_HI;
                    end
                end
                default: state <= RESET_LOW;
            endcase
        end
    end

    always_ff @(posedge w_clk) begin
        if (pop) pix_lo <= buf_pix[7:0];
    end

endmodule

/* rtl/lcd_top.sv */
//######################################
// ST7789 driver top level
// takes RGB565 pixels over a credit stream, brings the panel
// up and streams frames over 3-wire SPI. set the panel size
// and delays through the parameters
//######################################
`timescale 1ns/1ns

module lcd_top #(
    parameter int PANEL_W      = 240,
    parameter int PANEL_H      = 240,
    parameter int RESET_CYCLES = 10000,
    parameter int WAKE_CYCLES  = 10000,
    parameter int INIT_GAP     = 2048,
    parameter int FIFO_DEPTH   = 4
) (
    input  logic              w_clk,
    input  logic              reset,
    input  logic              pix_valid,
    input  pixel_pkg::pixel_t pix,
    output logic              pix_credit,
    output logic              lcd_res,
    output logic              lcd_scl,
    output logic              lcd_sda,
    output logic              lcd_dc
);
    import st7789_pkg::*;
    import pixel_pkg::*;

    logic      tmr_start;
    cycles_t   tmr_cycles;
    logic      tmr_done;
    item_idx_t tbl_idx;
    logic      tbl_window;
    lcd_item_t tbl_item;
    logic      buf_valid;
    pixel_t    buf_pix;
    logic      pop;
    lcd_item_t item;
    logic      item_valid;
    logic      tx_ready;

    lcd_sequencer #(
        .PANEL_W      (PANEL_W),
        .PANEL_H      (PANEL_H),
        .RESET_CYCLES (RESET_CYCLES),
        .WAKE_CYCLES  (WAKE_CYCLES),
        .INIT_GAP     (INIT_GAP)
    ) i_sequencer (
        .w_clk      (w_clk),
        .reset      (reset),
        .lcd_res    (lcd_res),
        .tmr_start  (tmr_start),
        .tmr_cycles (tmr_cycles),
        .tmr_done   (tmr_done),
        .tbl_idx    (tbl_idx),
        .tbl_window (tbl_window),
        .tbl_item   (tbl_item),
        .buf_valid  (buf_valid),
        .buf_pix    (buf_pix),
        .pop        (pop),
        .item       (item),
        .item_valid (item_valid),
        .tx_ready   (tx_ready)
    );

    lcd_delay_timer i_timer (
        .w_clk  (w_clk),
        .reset  (reset),
        .start  (tmr_start),
        .cycles (tmr_cycles),
        .done   (tmr_done)
    );

    lcd_command_rom #(
        .PANEL_W (PANEL_W),
        .PANEL_H (PANEL_H)
    ) i_command_rom (
        .idx    (tbl_idx),
        .window (tbl_window),
        .item   (tbl_item)
    );

    pixel_credit_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) i_pixel_fifo (
        .w_clk     (w_clk),
        .reset     (reset),
        .push      (pix_valid),
        .push_pix  (pix),
        .credit    (pix_credit),
        .pop       (pop),
        .buf_valid (buf_valid),
        .buf_pix   (buf_pix)
    );

    spi_byte_tx i_spi_tx (
        .w_clk      (w_clk),
        .reset      (reset),
        .item       (item),
        .item_valid (item_valid),
        .ready      (tx_ready),
        .sda        (lcd_sda),
        .scl        (lcd_scl),
        .dc         (lcd_dc)
    );

endmodule

/* test/lcd_ref.svh */
//########################################
// reference model for the ST7789 driver testbench
// gives the expected item at each decoded stream position
// and the value compare used by every test
//########################################
`ifndef LCD_REF_SVH
`define LCD_REF_SVH

function automatic lcd_item_t pack_item(input logic dc, input byte_t data);
    return '{dc: dc, data: data};
endfunction

// pixel k sent by the source
function automatic pixel_t pixel_value(input int k);
    return 16'(32'h1000 + k * 32'h0101);
endfunction

// init list, then frames of window items and pixel bytes
function automatic lcd_item_t ref_item(input int n);
    int        pos;
    int        q;
    pixel_t    px;
    lcd_item_t it;
    it = pack_item(1'b0, 8'h00);
    if (n < 9) begin
        case (n)
            0: it = pack_item(1'b0, 8'h01);   // software reset
            1: it = pack_item(1'b0, 8'h11);   // sleep out
            2: it = pack_item(1'b0, 8'h3A);
            3: it = pack_item(1'b1, 8'h55);   // RGB565
            4: it = pack_item(1'b0, 8'h36);
            5: it = pack_item(1'b1, 8'h00);
            6: it = pack_item(1'b0, 8'h21);
            7: it = pack_item(1'b0, 8'h13);
            8: it = pack_item(1'b0, 8'h29);   // display on
            default: ;
        endcase
    end else begin
        pos = (n - 9) % FRAME_ITEMS;
        if (pos < 11) begin
            case (pos)
                0:  it = pack_item(1'b0, 8'h2A);
                3:  it = pack_item(1'b1, 8'((TB_W - 1) >> 8));
                4:  it = pack_item(1'b1, 8'(TB_W - 1));
                5:  it = pack_item(1'b0, 8'h2B);
                8:  it = pack_item(1'b1, 8'((TB_H - 1) >> 8));
                9:  it = pack_item(1'b1, 8'(TB_H - 1));
                10: it = pack_item(1'b0, 8'h2C);
                default: it = pack_item(1'b1, 8'h00);   // window start bytes
            endcase
        end else begin
            q  = pos - 11;
            px = pixel_value(((n - 9) / FRAME_ITEMS) * FRAME_PIX + q / 2);
            it = pack_item(1'b1, (q % 2 == 0) ? px[15:8] : px[7:0]);
        end
    end
    return it;
endfunction

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
                 $time, name, got, exp);
    end
endtask

`endif

/* test/tb_lcd_top.sv */
//########################################
// testbench for the ST7789 driver top level
// small 4x3 panel; a credit-honoring pixel source feeds the DUT
// and an SPI decoder rebuilds items for comparison
//########################################
`timescale 1ns/1ns

module tb_lcd_top;
    import st7789_pkg::*;
    import pixel_pkg::*;

    localparam int TB_W         = 4;
    localparam int TB_H         = 3;
    localparam int TB_RESET     = 20;
    localparam int TB_DEPTH     = 4;
    localparam int FRAME_PIX    = TB_W * TB_H;
    localparam int FRAME_ITEMS  = 11 + 2 * FRAME_PIX;
    localparam int ITEM_TIMEOUT = 2000;   // cycles per decoded byte

    logic      w_clk     = 1'b0;
    logic      reset     = 1'b1;
    logic      pix_valid = 1'b0;
    pixel_t    pix       = '0;
    logic      pix_credit;
    logic      lcd_res;
    logic      lcd_scl;
    logic      lcd_sda;
    logic      lcd_dc;
    integer    seed = 32'h3c24;
    lcd_item_t rx_q[$];          // decoded SPI items
    logic      scl_q;
    logic [2:0] bit_cnt;
    logic [6:0] rx_bits;
    int        credit_total = 0;
    int        early_falls  = 0;
    int        src_credits  = 0;
    int        src_next     = 0;   // number of the next pixel to send
    logic      src_en       = 1'b0;
    int        chk_cnt      = 0;
    int        err_cnt      = 0;
    int        test_cnt     = 0;
    int        test_chk;
    int        test_err;
    string     test_name;
    logic      timed_out    = 1'b0;
    int        rx_pos       = 0;

    `include "lcd_ref.svh"

    lcd_top #(
        .PANEL_W      (TB_W),
        .PANEL_H      (TB_H),
        .RESET_CYCLES (TB_RESET),
        .WAKE_CYCLES  (20),
        .INIT_GAP     (24),
        .FIFO_DEPTH   (TB_DEPTH)
    ) i_lcd_top (
        .w_clk      (w_clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .pix_credit (pix_credit),
        .lcd_res    (lcd_res),
        .lcd_scl    (lcd_scl),
        .lcd_sda    (lcd_sda),
        .lcd_dc     (lcd_dc)
    );

    always #2 w_clk = ~w_clk;

    // SPI decoder plus credit and early clock monitors
    always @(posedge w_clk) begin
        if (reset) begin
            scl_q   <= 1'b1;
            bit_cnt <= '0;
        end else begin
            scl_q <= lcd_scl;
            if (scl_q && !lcd_scl && !lcd_res) early_falls <= early_falls + 1;
            if (pix_credit) credit_total <= credit_total + 1;
            if (lcd_scl && !scl_q) begin   // panel samples here
                rx_bits <= {rx_bits[5:0], lcd_sda};
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 3'd7) rx_q.push_back(pack_item(lcd_dc, {rx_bits, lcd_sda}));
            end
        end
    end

    // pixel source, sends only while it holds a credit
    always @(posedge w_clk) begin : source
        int avail;
        if (reset) begin
            src_credits = 0;
            pix_valid <= 1'b0;
        end else begin
            avail = src_credits + (pix_credit ? 1 : 0);
            if (src_en && avail > 0 && ($random(seed) & 3) != 0) begin
                pix_valid <= 1'b1;
                pix       <= pixel_value(src_next);
                src_next  = src_next + 1;
                avail     = avail - 1;
            end else begin
                pix_valid <= 1'b0;   // random gap
            end
            src_credits = avail;
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_chk  = chk_cnt;
        test_err  = err_cnt;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("test %s: %0d checks, %0d errors", test_name,
                 chk_cnt - test_chk, err_cnt - test_err);
    endtask

    task automatic next_item(output lcd_item_t it);
        int waited;
        waited = 0;
        while (rx_q.size() == 0 && waited < ITEM_TIMEOUT) begin
            @(negedge w_clk);
            waited++;
        end
        if (rx_q.size() == 0) begin
            timed_out = 1'b1;
            $display("timeout: no SPI byte decoded at position %0d", rx_pos);
            it = '0;
        end else begin
            it = rx_q.pop_front();
        end
    endtask

    task automatic expect_items(input int count);
        lcd_item_t it;
        for (int i = 0; i < count && !timed_out; i++) begin
            next_item(it);
            if (!timed_out) begin
                check_value($sformatf("item[%0d]", rx_pos), 32'(it), 32'(ref_item(rx_pos)));
                rx_pos++;
            end
        end
    endtask

    initial begin
        int waited;
        repeat (3) @(posedge w_clk);
        reset <= 1'b0;

        begin_test("reset_pulse");
        @(negedge w_clk);
        check_value("lcd_res", 32'(lcd_res), 32'd0);
        waited = 0;
        while (!lcd_res && waited < 200) begin
            @(negedge w_clk);
            waited++;
        end
        if (!lcd_res) begin
            timed_out = 1'b1;
            $display("timeout: panel reset never released");
        end
        check_value("lcd_res_low_long_enough", 32'(waited >= TB_RESET - 1), 32'd1);
        check_value("early_scl_falls", 32'(early_falls), 32'd0);
        end_test();

        begin_test("initial_credits");   // source still holds back
        check_value("credit_total", 32'(credit_total), 32'(TB_DEPTH));
        end_test();

        begin_test("init_sequence");
        expect_items(9);
        end_test();

        begin_test("window_cmds");
        expect_items(11);
        check_value("credit_total", 32'(credit_total), 32'(TB_DEPTH));
        end_test();

        begin_test("pixel_stream");
        src_en <= 1'b1;
        expect_items(3 * FRAME_ITEMS - 11);
        check_value("credit_total", 32'(credit_total), 32'(TB_DEPTH + 3 * FRAME_PIX));
        end_test();

        $display("summary: %0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0 && !timed_out) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+test
rtl/st7789_pkg.sv
rtl/pixel_pkg.sv
rtl/lcd_delay_timer.sv
rtl/lcd_command_rom.sv
rtl/pixel_credit_fifo.sv
rtl/spi_byte_tx.sv
rtl/lcd_sequencer.sv
rtl/lcd_top.sv
test/tb_lcd_top.sv

/* run.sh */
#!/bin/sh
# build and run the ST7789 driver testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f tb.f --top-module tb_lcd_top -o tb_lcd_top
./obj_dir/tb_lcd_top > sim.log 2>&1
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi
grep -q "ALL CHECKS PASSED" sim.log
